// File: verilog/display_pkg.sv
// ======================================================================
// 640x480 at 60 Hz display timing, 25.2 MHz nominal pixel clock
// both syncs active low, coordinates are unsigned
// ======================================================================

package display_pkg;

    localparam int CORDW = 10;  // enough for 799 and 524

    // horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

endpackage

// File: verilog/fb_pkg.sv
// ======================================================================
// framebuffer geometry and fizzlefade constants
// LFSR length must cover FB_PIXELS, taps give a maximal sequence
// ======================================================================

package fb_pkg;

    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15
    localparam int FB_DATAW  = 4;                     // palette index bits
    localparam int COLRW     = 12;                    // 4 bits per colour

    // fizzlefade LFSR, x^15 + x^14 + 1
    localparam int LFSR_LEN = 15;
    localparam logic [LFSR_LEN-1:0] LFSR_SEED = 15'd1;
    localparam logic [LFSR_LEN-1:0] LFSR_TAPS = 15'b110_0000_0000_0000;

    localparam logic [FB_DATAW-1:0] FADE_IDX = 4'hF;  // colour painted by the fade

    localparam int FADE_WAIT_DEF = 600;   // frames
    localparam int FADE_RATE_DEF = 3200;  // clocks per step

    localparam int PIPE_LAT = 3;  // coordinate to DVI outputs

endpackage

// File: verilog/display_timings.sv
// ======================================================================
// free running 640x480 counters, sync/de decoded from counter values
// frame_start fires in the last clock of the frame, not after reset
// ======================================================================
`timescale 1ns/1ns

module display_timings import display_pkg::*; (
    input  logic             clk_pix,
    input  logic             rst_n,
    output logic [CORDW-1:0] sx,           // horizontal position
    output logic [CORDW-1:0] sy,           // vertical position
    output logic             hsync,        // active low
    output logic             vsync,        // active low
    output logic             de,           // active video
    output logic             frame_start   // one clock strobe
);

    logic line_end;
    assign line_end = (sx == CORDW'(H_TOTAL - 1));

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            sx <= line_end ? '0 : sx + 1'b1;
            if (line_end) begin
                sy <= (sy == CORDW'(V_TOTAL - 1)) ? '0 : sy + 1'b1;  // wrap at frame end
            end
        end
    end

    // sync pulses sit after the front porch
    assign hsync = ~(sx >= CORDW'(H_ACTIVE + H_FP) && sx < CORDW'(H_ACTIVE + H_FP + H_SYNC));
    assign vsync = ~(sy >= CORDW'(V_ACTIVE + V_FP) && sy < CORDW'(V_ACTIVE + V_FP + V_SYNC));
    assign de    = (sx < CORDW'(H_ACTIVE)) && (sy < CORDW'(V_ACTIVE));

    assign frame_start = line_end && (sy == CORDW'(V_TOTAL - 1));

    // counter stays in range
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx < CORDW'(H_TOTAL))
        else $error("sx out of range: %0d", sx);

endmodule

// File: verilog/lfsr.sv
// ======================================================================
// Fibonacci LFSR, shifts left, feedback enters at bit 0
// seed must be nonzero or the register locks up
// ======================================================================
`timescale 1ns/1ns

module lfsr import fb_pkg::*; (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                en,     // advance one state
    output logic [LFSR_LEN-1:0] sreg
);

    logic fb;
    assign fb = ^(sreg & LFSR_TAPS);  // xor of tapped bits

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sreg <= LFSR_SEED;
        end else if (en) begin
            sreg <= {sreg[LFSR_LEN-2:0], fb};
        end
    end

    // all zero state is unreachable from a valid seed
    a_not_zero: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sreg != '0)
        else $error("lfsr reached zero state");

endmodule

// File: verilog/fade_timer.sv
// ======================================================================
// frame count before the fade, then step strobe every FADE_RATE clocks
// divider restarts from zero each time fade_run rises
// ======================================================================
`timescale 1ns/1ns

module fade_timer import fb_pkg::*; #(
    parameter int FADE_WAIT = FADE_WAIT_DEF,  // frames to wait
    parameter int FADE_RATE = FADE_RATE_DEF   // clocks per step
) (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic frame_start,  // frame tick
    input  logic fade_run,     // divider enable level
    output logic wait_done,
    output logic step
);

    localparam int WAITW = (FADE_WAIT > 0) ? $clog2(FADE_WAIT + 1) : 1;
    localparam int RATEW = (FADE_RATE > 1) ? $clog2(FADE_RATE) : 1;

    logic [WAITW-1:0] cnt_wait;
    logic [RATEW-1:0] cnt_rate;

    assign wait_done = (cnt_wait == WAITW'(FADE_WAIT));  // saturated

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cnt_wait <= '0;
        end else if (frame_start && !wait_done) begin
            cnt_wait <= cnt_wait + 1'b1;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cnt_rate <= '0;
            step     <= 1'b0;
        end else if (!fade_run) begin
            cnt_rate <= '0;  // hold divider idle
            step     <= 1'b0;
        end else if (cnt_rate == RATEW'(FADE_RATE - 1)) begin
            cnt_rate <= '0;
            step     <= 1'b1;
        end else begin
            cnt_rate <= cnt_rate + 1'b1;
            step     <= 1'b0;
        end
    end

endmodule

// File: verilog/fade_ctrl.sv
// ======================================================================
// WAIT -> FADE -> DONE sequencer, one framebuffer write per step
// write address is sreg-1 so addresses past the frame are possible
// ======================================================================
`timescale 1ns/1ns

module fade_ctrl import fb_pkg::*; (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                wait_done,
    input  logic                step,
    input  logic [LFSR_LEN-1:0] sreg,
    output logic                fade_run,
    output logic                lfsr_en,
    output logic                fb_we,
    output logic [FB_ADDRW-1:0] fb_addr_write,
    output logic [FB_DATAW-1:0] fb_cidx_write,
    output logic                fade_done
);

    typedef enum logic [1:0] {WAIT, FADE, DONE} state_t;
    state_t state;

    logic [LFSR_LEN-1:0] sreg_next;  // state after this step
    logic                last_step;

    assign sreg_next = {sreg[LFSR_LEN-2:0], ^(sreg & LFSR_TAPS)};
    assign last_step = (sreg_next == LFSR_SEED);  // sequence wraps to seed

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WAIT;
            lfsr_en <= 1'b0;
            fb_we   <= 1'b0;
        end else begin
            lfsr_en <= 1'b0;
            fb_we   <= 1'b0;
            case (state)
                WAIT: if (wait_done) state <= FADE;
                FADE: begin
                    if (step) begin
                        lfsr_en <= 1'b1;
                        fb_we   <= 1'b1;
                        if (last_step) state <= DONE;
                    end
                end
                default: state <= DONE;  // done is terminal
            endcase
        end
    end

    // write payload, captured with the strobe
    always_ff @(posedge clk_pix) begin
        if (step && state == FADE) begin
            fb_addr_write <= sreg - 1'b1;
            fb_cidx_write <= FADE_IDX;
        end
    end

    assign fade_run  = (state == FADE);
    assign fade_done = (state == DONE);

    // strobes only follow a step taken in FADE
    a_we_in_fade: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (fb_we || lfsr_en) |-> $past(state == FADE && step))
        else $error("write strobe outside fade");

endmodule

// File: verilog/framebuffer.sv
// ======================================================================
// simple dual port RAM, one clock, registered read, starts all zero
// writes at FB_PIXELS and above are dropped
// ======================================================================
`timescale 1ns/1ns

module framebuffer import fb_pkg::*; (
    input  logic                clk_pix,
    input  logic                we,
    input  logic [FB_ADDRW-1:0] addr_write,
    input  logic [FB_DATAW-1:0] data_in,
    input  logic [FB_ADDRW-1:0] addr_read,
    output logic [FB_DATAW-1:0] data_out
);

    logic [FB_DATAW-1:0] mem [FB_PIXELS] = '{default: '0};  // palette index 0

    logic wr_ok;
    assign wr_ok = we && (addr_write < FB_ADDRW'(FB_PIXELS));  // range guard

    always_ff @(posedge clk_pix) begin
        if (wr_ok) begin
            mem[addr_write] <= data_in;
        end
    end

    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];  // one clock read latency
    end

endmodule

// File: verilog/pixel_pipe.sv
// ======================================================================
// framebuffer scan, palette lookup and DVI output registers
// outputs lag sx/sy by PIPE_LAT clocks, syncs delayed to match
// ======================================================================
`timescale 1ns/1ns

module pixel_pipe import display_pkg::*, fb_pkg::*; (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic [CORDW-1:0]     sx,
    input  logic [CORDW-1:0]     sy,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 de,
    input  logic                 frame_start,
    output logic [FB_ADDRW-1:0]  fb_addr_read,
    input  logic [FB_DATAW-1:0]  fb_cidx_read,   // one clock after address
    output logic                 dvi_hsync,
    output logic                 dvi_vsync,
    output logic                 dvi_de,
    output logic [COLRW/3-1:0]   dvi_r,
    output logic [COLRW/3-1:0]   dvi_g,
    output logic [COLRW/3-1:0]   dvi_b
);

    logic                paint;     // inside the 160x120 region
    logic [FB_DATAW-1:0] cidx_q;    // index register after the RAM
    logic [COLRW-1:0]    colr;
    logic [COLRW-1:0]    palette [2**FB_DATAW];

    // delay lines for the first PIPE_LAT-1 stages
    logic [PIPE_LAT-2:0] paint_sr, hsync_sr, vsync_sr, de_sr;

    initial $readmemh("palette.mem", palette);

    assign paint = (sx < CORDW'(FB_WIDTH)) && (sy < CORDW'(FB_HEIGHT));

    // read address follows raster order in the paint region
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            fb_addr_read <= '0;
        end else if (frame_start) begin
            fb_addr_read <= '0;
        end else if (paint) begin
            fb_addr_read <= fb_addr_read + 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        cidx_q <= fb_cidx_read;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            paint_sr <= '0;
            hsync_sr <= '1;  // syncs idle high
            vsync_sr <= '1;
            de_sr    <= '0;
        end else begin
            paint_sr <= {paint, paint_sr[PIPE_LAT-2:1]};
            hsync_sr <= {hsync, hsync_sr[PIPE_LAT-2:1]};
            vsync_sr <= {vsync, vsync_sr[PIPE_LAT-2:1]};
            de_sr    <= {de, de_sr[PIPE_LAT-2:1]};
        end
    end

    // border outside the framebuffer is black
    assign colr = paint_sr[0] ? palette[cidx_q] : '0;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            {dvi_r, dvi_g, dvi_b} <= '0;
        end else begin
            dvi_hsync <= hsync_sr[0];
            dvi_vsync <= vsync_sr[0];
            dvi_de    <= de_sr[0];
            {dvi_r, dvi_g, dvi_b} <= colr;  // red in the top nibble
        end
    end

endmodule

// File: verilog/fizzle_top.sv
// ======================================================================
// fizzlefade video top, pixel clock and reset come from outside
// FADE_WAIT in frames, FADE_RATE in pixel clocks per step
// ======================================================================
`timescale 1ns/1ns

module fizzle_top import display_pkg::*, fb_pkg::*; #(
    parameter int FADE_WAIT = FADE_WAIT_DEF,
    parameter int FADE_RATE = FADE_RATE_DEF
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    output logic               dvi_hsync,
    output logic               dvi_vsync,
    output logic               dvi_de,
    output logic [COLRW/3-1:0] dvi_r,
    output logic [COLRW/3-1:0] dvi_g,
    output logic [COLRW/3-1:0] dvi_b,
    output logic               fade_done
);

    // raster
    logic [CORDW-1:0] sx, sy;
    logic             hsync, vsync, de, frame_start;

    // fade control
    logic                wait_done, step, fade_run, lfsr_en;
    logic [LFSR_LEN-1:0] sreg;

    // framebuffer ports
    logic                fb_we;
    logic [FB_ADDRW-1:0] fb_addr_write, fb_addr_read;
    logic [FB_DATAW-1:0] fb_cidx_write, fb_cidx_read;

    display_timings u_timings (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .frame_start
    );

    fade_timer #(
        .FADE_WAIT(FADE_WAIT),
        .FADE_RATE(FADE_RATE)
    ) u_timer (
        .clk_pix, .rst_n, .frame_start, .fade_run, .wait_done, .step
    );

    fade_ctrl u_ctrl (
        .clk_pix, .rst_n, .wait_done, .step, .sreg, .fade_run, .lfsr_en,
        .fb_we, .fb_addr_write, .fb_cidx_write, .fade_done
    );

    lfsr u_lfsr (
        .clk_pix, .rst_n, .en(lfsr_en), .sreg
    );

    framebuffer u_fb (
        .clk_pix,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .data_in(fb_cidx_write),
        .addr_read(fb_addr_read),
        .data_out(fb_cidx_read)
    );

    pixel_pipe u_pipe (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .frame_start,
        .fb_addr_read, .fb_cidx_read,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

endmodule

// File: dv/tb_fizzle_top.sv
// ======================================================================
// fizzlefade testbench, short wait and rate so the fade ends in frame two
// run from the project root so palette.mem is found
// ======================================================================
`timescale 1ns/1ns

module tb_fizzle_top import display_pkg::*, fb_pkg::*; ();

    localparam int TB_WAIT    = 1;                         // frames
    localparam int TB_RATE    = 4;                         // clocks per step
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam int FADE_STEPS = 2**LFSR_LEN - 1;           // every nonzero state
    localparam int FADE_CLKS  = TB_WAIT * FRAME_CLKS + FADE_STEPS * TB_RATE;
    localparam int SLACK      = 16;                        // pipeline and count offset
    localparam int LIMIT_NS   = (4 * FRAME_CLKS + 2000) * 40;
    localparam int BLACK      = -1;

    logic       clk_pix;
    logic       rst_n;
    logic       dvi_hsync;
    logic       dvi_vsync;
    logic       dvi_de;
    logic       fade_done;
    logic [3:0] dvi_r;
    logic [3:0] dvi_g;
    logic [3:0] dvi_b;

    logic [COLRW-1:0] pal [16];
    logic [COLRW-1:0] shot [2][H_ACTIVE*V_ACTIVE];  // frame before and after fade

    // probe table, one entry per test
    string t_name [$];
    int    t_phase[$];  // 0 first frame, 1 frame after fade_done
    int    t_x    [$];
    int    t_y    [$];
    int    t_idx  [$];  // palette index or BLACK

    int passes = 0;
    int fails  = 0;

    // output monitor state
    int clks    = 0;
    int tx      = 0;
    int ty      = 0;
    int slot    = 0;    // capture slot of the current frame, -1 none
    bit post_started = 0;
    bit post_done    = 0;
    bit prev_hs = 1;
    bit prev_vs = 1;
    bit prev_de = 0;
    int hs_low  = 0;
    int hs_fall = -1;
    int vs_low  = 0;
    int vs_fall = -1;
    int de_run  = 0;
    int lines   = 0;
    int hs_err  = 0;
    int de_err  = 0;
    int vs_err  = 0;
    int fade_at = -1;   // clock of the fade_done rise
    bit fade_drop = 0;

    fizzle_top #(
        .FADE_WAIT(TB_WAIT),
        .FADE_RATE(TB_RATE)
    ) UUT (
        .clk_pix, .rst_n, .dvi_hsync, .dvi_vsync, .dvi_de,
        .dvi_r, .dvi_g, .dvi_b, .fade_done
    );

    always #20 clk_pix = ~clk_pix;  // 40 ns period

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the post-fade frame was captured");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic add_probe(string name, int phase, int x, int y, int idx);
        t_name.push_back(name);
        t_phase.push_back(phase);
        t_x.push_back(x);
        t_y.push_back(y);
        t_idx.push_back(idx);
    endtask

    // outputs sampled on the falling edge, midway between DUT updates
    always @(negedge clk_pix) begin
        if (rst_n) begin
            clks++;
            if (!dvi_hsync) hs_low++;
            if (prev_hs && !dvi_hsync) begin
                if (hs_fall >= 0 && clks - hs_fall != H_TOTAL) begin
                    hs_err++;
                    if (hs_err <= 3) $display("hsync period %0d clocks, expected %0d",
                                              clks - hs_fall, H_TOTAL);
                end
                hs_fall = clks;
            end
            if (!prev_hs && dvi_hsync) begin
                if (hs_low != H_SYNC) begin
                    hs_err++;
                    if (hs_err <= 3) $display("hsync low %0d clocks, expected %0d",
                                              hs_low, H_SYNC);
                end
                hs_low = 0;
            end
            // pixel capture on own x/y counters
            if (dvi_de) begin
                if (slot >= 0 && tx < H_ACTIVE && ty < V_ACTIVE)
                    shot[slot][ty * H_ACTIVE + tx] = {dvi_r, dvi_g, dvi_b};
                tx++;
                de_run++;
            end
            if (prev_de && !dvi_de) begin  // end of an active line
                if (de_run != H_ACTIVE) begin
                    de_err++;
                    if (de_err <= 3) $display("de high %0d clocks, expected %0d",
                                              de_run, H_ACTIVE);
                end
                de_run = 0;
                tx = 0;
                ty++;
                lines++;
            end
            if (!dvi_vsync) vs_low++;
            if (prev_vs && !dvi_vsync) begin  // active region of a frame is over
                if (lines != V_ACTIVE) begin
                    de_err++;
                    $display("%0d active lines in frame, expected %0d", lines, V_ACTIVE);
                end
                if (vs_fall >= 0 && clks - vs_fall != FRAME_CLKS) begin
                    vs_err++;
                    $display("vsync period %0d clocks, expected %0d",
                             clks - vs_fall, FRAME_CLKS);
                end
                vs_fall = clks;
                lines = 0;
                ty = 0;
                if (slot == 1) post_done = 1;
                slot = -1;
                if (fade_at >= 0 && !post_started) begin
                    slot = 1;
                    post_started = 1;
                end
            end
            if (!prev_vs && dvi_vsync) begin
                if (vs_low != V_SYNC * H_TOTAL) begin
                    vs_err++;
                    $display("vsync low %0d clocks, expected %0d", vs_low, V_SYNC * H_TOTAL);
                end
                vs_low = 0;
            end
            // fade_done rises once, near wait frames plus one step per state
            if (fade_done && fade_at < 0) begin
                fade_at = clks;
                if (clks < FADE_CLKS - SLACK || clks > FADE_CLKS + SLACK) begin
                    $display("MISMATCH fade_done_rise expected %0d actual %0d",
                             FADE_CLKS, clks);
                    fails++;
                end else begin
                    $display("ok fade_done_rise at clock %0d", clks);
                    passes++;
                end
            end
            if (!fade_done && fade_at >= 0 && !fade_drop) begin
                fade_drop = 1;
                $display("fade_done went low again after it had risen");
                fails++;
            end
            prev_hs = dvi_hsync;
            prev_vs = dvi_vsync;
            prev_de = dvi_de;
        end
    end

    initial begin
        int               k;
        int               rx;
        int               ry;
        logic [COLRW-1:0] exp_c;
        logic [COLRW-1:0] got_c;

        clk_pix = 1'b0;
        rst_n   = 1'b0;
        void'($urandom(32'hdc5f_ee98));
        $readmemh("palette.mem", pal);

        //        name                  phase  x    y    index
        add_probe("pre_origin",           0,   0,   0, 0);
        add_probe("pre_last_pixel",       0, 159, 119, 0);
        add_probe("pre_centre",           0,  80,  60, 0);
        add_probe("pre_right_border",     0, 160,   0, BLACK);
        add_probe("pre_below_fb",         0,   0, 120, BLACK);
        add_probe("pre_far_corner",       0, 639, 479, BLACK);
        add_probe("post_origin",          1,   0,   0, 15);
        add_probe("post_last_pixel",      1, 159, 119, 15);
        add_probe("post_first_row_end",   1, 159,   0, 15);
        add_probe("post_last_row_start",  1,   0, 119, 15);
        add_probe("post_right_border",    1, 160,   0, BLACK);
        add_probe("post_below_last",      1, 159, 120, BLACK);
        add_probe("post_mid_screen",      1, 320, 240, BLACK);
        add_probe("post_far_corner",      1, 639, 479, BLACK);
        for (k = 0; k < 4; k++) begin
            rx = $urandom_range(FB_WIDTH - 1);
            ry = $urandom_range(FB_HEIGHT - 1);
            add_probe($sformatf("pre_rand_%0d", k), 0, rx, ry, 0);
            add_probe($sformatf("post_rand_%0d", k), 1, rx, ry, 15);
            rx = $urandom_range(H_ACTIVE - 1, FB_WIDTH);  // right of the fb
            ry = $urandom_range(V_ACTIVE - 1);
            add_probe($sformatf("post_rand_out_%0d", k), 1, rx, ry, BLACK);
        end

        @(posedge clk_pix);
        @(negedge clk_pix);
        if (dvi_de !== 1'b0 || fade_done !== 1'b0 || {dvi_r, dvi_g, dvi_b} !== '0
            || dvi_hsync !== 1'b1 || dvi_vsync !== 1'b1) begin
            $display("outputs not idle during reset");
            fails++;
        end else begin
            $display("ok reset_hold");
            passes++;
        end
        @(posedge clk_pix);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk_pix);
        if (dvi_de !== 1'b0 || fade_done !== 1'b0 || {dvi_r, dvi_g, dvi_b} !== '0
            || dvi_hsync !== 1'b1 || dvi_vsync !== 1'b1) begin
            $display("outputs not idle right after reset");
            fails++;
        end else begin
            $display("ok reset_release");
            passes++;
        end

        wait (post_done);  // watchdog covers a missing fade

        for (k = 0; k < t_name.size(); k++) begin
            exp_c = (t_idx[k] == BLACK) ? '0 : pal[t_idx[k]];
            got_c = shot[t_phase[k]][t_y[k] * H_ACTIVE + t_x[k]];
            if (got_c !== exp_c) begin
                $display("MISMATCH %s expected %03h actual %03h", t_name[k], exp_c, got_c);
                fails++;
            end else begin
                $display("ok %s %03h", t_name[k], got_c);
                passes++;
            end
        end

        if (hs_err != 0) begin
            $display("hsync timing wrong %0d times", hs_err);
            fails++;
        end else begin
            $display("ok hsync_timing");
            passes++;
        end
        if (de_err != 0) begin
            $display("de timing wrong %0d times", de_err);
            fails++;
        end else begin
            $display("ok de_timing");
            passes++;
        end
        if (vs_err != 0) begin
            $display("vsync timing wrong %0d times", vs_err);
            fails++;
        end else begin
            $display("ok vsync_timing");
            passes++;
        end

        $display("%0d tests passed, %0d failed", passes, fails);
        if (fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: palette.mem
// one 12-bit RGB colour per palette index 0 to 15, red in the top nibble
137
222
444
666
888
aaa
800
080
008
880
808
088
f80
0f8
8af
fc0

// File: sources.f
verilog/display_pkg.sv
verilog/fb_pkg.sv
verilog/display_timings.sv
verilog/lfsr.sv
verilog/fade_timer.sv
verilog/fade_ctrl.sv
verilog/framebuffer.sv
verilog/pixel_pipe.sv
verilog/fizzle_top.sv
dv/tb_fizzle_top.sv

// File: run.sh
#!/bin/sh
# build and run the fizzlefade testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fizzle_top \
    -f sources.f -o tb_fizzle_top > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_fizzle_top > sim.log 2>&1
grep -q "=== FAIL ===" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
